// ==== hdl/dbg_mem_pkg.sv ====
// address map, sizes, command layout and RV32I encoders shared by the debug memory RTL
package dbg_mem_pkg;

  // ----------------------------------------
  // sizes
  // ----------------------------------------
  localparam int unsigned nr_harts      = 2;
  localparam int unsigned dbg_addr_bits = 12;
  localparam int unsigned data_count    = 2;
  localparam int unsigned progbuf_size  = 4;
  localparam int unsigned abs_cmd_size  = 10;

  typedef logic [0:0]  hart_sel_t;
  typedef logic [31:0] instr_t;

  // ----------------------------------------
  // address map of the 4 KiB window
  // ----------------------------------------
  localparam logic [dbg_addr_bits-1:0] halted_addr       = 12'h100;
  localparam logic [dbg_addr_bits-1:0] going_addr        = 12'h108;
  localparam logic [dbg_addr_bits-1:0] resuming_addr     = 12'h110;
  localparam logic [dbg_addr_bits-1:0] exception_addr    = 12'h118;
  localparam logic [dbg_addr_bits-1:0] whereto_addr      = 12'h300;
  // ten-word program ends right below the program buffer
  localparam logic [dbg_addr_bits-1:0] abs_cmd_base_addr = 12'h348;
  localparam logic [dbg_addr_bits-1:0] abs_cmd_end_addr  = 12'h36F;
  localparam logic [dbg_addr_bits-1:0] progbuf_base_addr = 12'h370;
  localparam logic [dbg_addr_bits-1:0] progbuf_end_addr  = 12'h37F;
  localparam logic [dbg_addr_bits-1:0] data_addr         = 12'h380;
  localparam logic [dbg_addr_bits-1:0] data_end_addr     = 12'h387;
  localparam logic [dbg_addr_bits-1:0] flags_base_addr   = 12'h400;
  localparam logic [dbg_addr_bits-1:0] halt_addr         = 12'h800;
  localparam logic [dbg_addr_bits-1:0] resume_addr       = 12'h804;
  // flag bytes stop where the external ROM begins
  localparam logic [dbg_addr_bits-1:0] flags_end_addr    = halt_addr - 12'h001;

  // control FSM encodings
  localparam logic [1:0] st_idle   = 2'd0;
  localparam logic [1:0] st_go     = 2'd1;
  localparam logic [1:0] st_resume = 2'd2;
  localparam logic [1:0] st_exec   = 2'd3;

  // registers and CSRs used by the generated program
  localparam logic [4:0]  reg_zero      = 5'd0;
  localparam logic [4:0]  reg_s0        = 5'd8;
  localparam logic [11:0] csr_dscratch0 = 12'h7B2;

  // ----------------------------------------
  // debugger command word
  // ----------------------------------------
  typedef struct packed {
    logic [7:0]  cmdtype;
    logic [23:0] control;
  } cmd_raw_t;

  // access register view, bits 31:23 are type and a reserved bit
  typedef struct packed {
    logic [8:0]  upper;
    logic [2:0]  aarsize;
    logic        aarpostincrement;
    logic        postexec;
    logic        transfer;
    logic        write;
    logic [15:0] regno;
  } cmd_ar_t;

  typedef union packed {
    cmd_raw_t raw;
    cmd_ar_t  ar;
  } cmd_word_u;

  typedef enum logic [2:0] {
    cmderr_none          = 3'd0,
    cmderr_not_supported = 3'd2,
    cmderr_exception     = 3'd3,
    cmderr_halt_resume   = 3'd4
  } cmderr_e;

  // ----------------------------------------
  // RV32I encoders
  // ----------------------------------------
  function automatic instr_t enc_jal(logic [4:0] rd, logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  function automatic instr_t enc_lw(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
    return {imm, rs1, 3'b010, rd, 7'b0000011};
  endfunction

  function automatic instr_t enc_sw(logic [4:0] rs2, logic [4:0] rs1, logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  // csrrw with rd x0
  function automatic instr_t enc_csrw(logic [11:0] csr, logic [4:0] rs1);
    return {csr, rs1, 3'b001, 5'd0, 7'b1110011};
  endfunction

  // csrrs with rs1 x0
  function automatic instr_t enc_csrr(logic [4:0] rd, logic [11:0] csr);
    return {csr, 5'd0, 3'b010, rd, 7'b1110011};
  endfunction

  function automatic instr_t enc_nop();
    return 32'h0000_0013;
  endfunction

  function automatic instr_t enc_ebreak();
    return 32'h0010_0073;
  endfunction

  function automatic instr_t enc_illegal();
    return 32'h0000_0000;
  endfunction

endpackage

// ==== hdl/dbg_bus_if.sv ====
// hart memory bus from the top level into the debug window address decoder
`timescale 1ns/1ns
interface dbg_bus_if;
  logic        req;
  logic        we;
  logic [31:0] addr;
  logic [31:0] wdata;
  logic [3:0]  be;
  // registered answer, one cycle after the read
  logic [31:0] rdata;

  // requester side
  modport host (
    output req, we, addr, wdata, be,
    input  rdata
  );

  // window side
  modport target (
    input  req, we, addr, wdata, be,
    output rdata
  );
endinterface

// ==== hdl/hart_ctrl_fsm.sv ====
// control FSM that starts abstract commands and resumes on the selected hart
`timescale 1ns/1ns
module hart_ctrl_fsm
  import dbg_mem_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                ndmreset_i,
  input  hart_sel_t           hartsel_i,
  input  logic [nr_harts-1:0] haltreq_i,
  input  logic [nr_harts-1:0] resumereq_i,
  input  logic [nr_harts-1:0] halted_i,
  input  logic [nr_harts-1:0] resuming_i,
  input  logic                going_i,
  input  logic [nr_harts-1:0] halted_w_i,
  input  logic                exception_i,
  input  logic                unsupported_i,
  input  logic                cmd_valid_i,
  output logic                go_o,
  output logic                resume_o,
  output logic                cmd_busy_o,
  output logic                cmderror_valid_o,
  output cmderr_e             cmderror_o
);

  logic [1:0] state_q;
  logic [1:0] state_d;
  logic       resume_ok;

  // resume only a parked hart that has acked nothing yet and is not asked to halt
  assign resume_ok = resumereq_i[hartsel_i] && halted_i[hartsel_i] &&
                     !resuming_i[hartsel_i] && !haltreq_i[hartsel_i];

  assign cmd_busy_o = (state_q != st_idle);

  // ----------------------------------------
  // next state and flag outputs
  // ----------------------------------------
  always_comb begin
    state_d          = state_q;
    go_o             = 1'b0;
    resume_o         = 1'b0;
    cmderror_valid_o = 1'b0;
    cmderror_o       = cmderr_none;
    case (state_q)
      st_idle: begin
        if (cmd_valid_i) begin
          // not_supported wins over a hart that is not halted
          if (unsupported_i) begin
            cmderror_valid_o = 1'b1;
            cmderror_o       = cmderr_not_supported;
          end else if (!halted_i[hartsel_i]) begin
            cmderror_valid_o = 1'b1;
            cmderror_o       = cmderr_halt_resume;
          end else begin
            state_d = st_go;
          end
        end else if (resume_ok) begin
          state_d = st_resume;
        end
      end
      st_go: begin
        // hart sees the go flag, leaves once it writes going
        go_o = 1'b1;
        if (going_i) begin
          state_d = st_exec;
        end
      end
      st_resume: begin
        resume_o = 1'b1;
        if (resuming_i[hartsel_i]) begin
          state_d = st_idle;
        end
      end
      default: begin
        // program runs until the hart parks again
        if (halted_w_i[hartsel_i]) begin
          state_d = st_idle;
        end
      end
    endcase

    // exception during the program
    if (exception_i) begin
      cmderror_valid_o = 1'b1;
      cmderror_o       = cmderr_exception;
    end

    // hart under reset drops any pending go or resume
    if (ndmreset_i) begin
      state_d  = st_idle;
      go_o     = 1'b0;
      resume_o = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= st_idle;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

// ==== hdl/abstract_cmd_gen.sv ====
// builds the ten-word abstract-command program for access register commands
`timescale 1ns/1ns
module abstract_cmd_gen
  import dbg_mem_pkg::*;
(
  input  cmd_word_u                 cmd_i,
  output instr_t [abs_cmd_size-1:0] prog_o,
  output logic                      to_progbuf_o,
  output logic                      unsupported_o
);

  logic        ar_ok;
  logic        xfer_ok;
  logic        skip_ok;
  logic        is_gpr;
  logic [4:0]  gpr;
  logic [11:0] csr;

  // type from the raw view, fields from the access register view
  assign ar_ok   = (cmd_i.raw.cmdtype == 8'd0) && !cmd_i.ar.aarpostincrement;
  assign is_gpr  = cmd_i.ar.regno[12];
  assign gpr     = cmd_i.ar.regno[4:0];
  assign csr     = cmd_i.ar.regno[11:0];

  // 32-bit and smaller, no reserved range, no FPR
  assign xfer_ok = ar_ok && cmd_i.ar.transfer && (cmd_i.ar.aarsize <= 3'd2) &&
                   (cmd_i.ar.regno[15:14] == 2'b00) && !(is_gpr && cmd_i.ar.regno[5]);
  // no transfer, straight into the program buffer
  assign skip_ok = ar_ok && !cmd_i.ar.transfer && cmd_i.ar.postexec;

  assign to_progbuf_o  = cmd_i.ar.postexec && !cmd_i.ar.transfer;
  assign unsupported_o = !(xfer_ok || skip_ok);

  // ----------------------------------------
  // program words
  // ----------------------------------------
  always_comb begin
    // default program traps and pads before going back to the park loop
    prog_o[0] = enc_illegal();
    for (int i = 1; i < abs_cmd_size - 1; i++) begin
      prog_o[i] = enc_nop();
    end
    prog_o[abs_cmd_size-1] = enc_ebreak();

    if (unsupported_o) begin
      // leave at once
      prog_o[0] = enc_ebreak();
    end else begin
      prog_o[0] = enc_nop();
      if (xfer_ok && is_gpr) begin
        // GPR moves straight between the register and data0, base x0
        prog_o[1] = cmd_i.ar.write ? enc_lw(gpr, reg_zero, data_addr) :
                                     enc_sw(gpr, reg_zero, data_addr);
      end else if (xfer_ok) begin
        // CSR goes through s0, saved in dscratch0 around the access
        prog_o[1] = enc_csrw(csr_dscratch0, reg_s0);
        if (cmd_i.ar.write) begin
          prog_o[2] = enc_lw(reg_s0, reg_zero, data_addr);
          prog_o[3] = enc_csrw(csr, reg_s0);
        end else begin
          prog_o[2] = enc_csrr(reg_s0, csr);
          prog_o[3] = enc_sw(reg_s0, reg_zero, data_addr);
        end
        prog_o[4] = enc_csrr(reg_s0, csr_dscratch0);
      end
      // last word falls through into the program buffer
      if (cmd_i.ar.postexec) begin
        prog_o[abs_cmd_size-1] = enc_nop();
      end
    end
  end

endmodule

// ==== hdl/dbg_mem_decoder.sv ====
// hart-side address decoder of the debug window with halt state and read data register
`timescale 1ns/1ns
module dbg_mem_decoder
  import dbg_mem_pkg::*;
(
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             ndmreset_i,
  input  hart_sel_t                        hartsel_i,
  dbg_bus_if.target                        bus,
  input  logic [nr_harts-1:0]              resumereq_i,
  input  logic                             clear_resumeack_i,
  input  logic                             go_i,
  input  logic                             resume_i,
  input  logic                             cmd_busy_i,
  input  instr_t [abs_cmd_size-1:0]        prog_i,
  input  logic                             to_progbuf_i,
  input  logic [progbuf_size-1:0][31:0]    progbuf_i,
  input  logic [data_count-1:0][31:0]      data_i,
  output logic [data_count-1:0][31:0]      data_o,
  output logic                             data_valid_o,
  output logic [nr_harts-1:0]              halted_o,
  output logic [nr_harts-1:0]              resuming_o,
  output logic                             going_o,
  output logic [nr_harts-1:0]              halted_w_o,
  output logic                             exception_o
);

  logic [dbg_addr_bits-1:0]        addr;
  logic [dbg_addr_bits-3:0]        word_a;
  logic [$clog2(data_count)-1:0]   data_idx;
  logic [$clog2(progbuf_size)-1:0] pb_idx;
  logic [$clog2(abs_cmd_size)-1:0] abs_idx;
  hart_sel_t                       wdata_hart;
  logic                            flag_hit;
  logic [1:0]                      flag_lane;
  logic [dbg_addr_bits-1:0]        whereto_tgt;
  logic [nr_harts-1:0]             halted_q;
  logic [nr_harts-1:0]             halted_d;
  logic [nr_harts-1:0]             resuming_q;
  logic [nr_harts-1:0]             resuming_d;
  logic [31:0]                     rdata_q;
  logic [31:0]                     rdata_d;

  assign addr       = bus.addr[dbg_addr_bits-1:0];
  assign word_a     = addr[dbg_addr_bits-1:2];
  assign data_idx   = $clog2(data_count)'(word_a - data_addr[dbg_addr_bits-1:2]);
  assign pb_idx     = $clog2(progbuf_size)'(word_a - progbuf_base_addr[dbg_addr_bits-1:2]);
  assign abs_idx    = $clog2(abs_cmd_size)'(word_a - abs_cmd_base_addr[dbg_addr_bits-1:2]);
  // hart index of halted and resuming writes comes in wdata
  assign wdata_hart = bus.wdata[$bits(hart_sel_t)-1:0];

  // one flag byte per hart, four harts to a word
  assign flag_hit  = (word_a == flags_base_addr[dbg_addr_bits-1:2] +
                     (dbg_addr_bits-2)'(hartsel_i >> 2));
  assign flag_lane = 2'(hartsel_i);

  // running command overrides a pending resume
  always_comb begin
    whereto_tgt = resume_addr;
    if (cmd_busy_i) begin
      whereto_tgt = to_progbuf_i ? progbuf_base_addr : abs_cmd_base_addr;
    end
  end

  // ----------------------------------------
  // hart writes
  // ----------------------------------------
  always_comb begin
    halted_d     = halted_q;
    resuming_d   = resuming_q;
    halted_w_o   = '0;
    going_o      = 1'b0;
    exception_o  = 1'b0;
    data_valid_o = 1'b0;
    data_o       = data_i;

    // debugger acks the resume
    if (clear_resumeack_i) begin
      resuming_d[hartsel_i] = 1'b0;
    end

    if (bus.req && bus.we) begin
      unique case (addr) inside
        halted_addr: begin
          halted_w_o[wdata_hart] = 1'b1;
          halted_d[wdata_hart]   = 1'b1;
        end
        going_addr: going_o = 1'b1;
        resuming_addr: begin
          halted_d[wdata_hart]   = 1'b0;
          resuming_d[wdata_hart] = 1'b1;
        end
        exception_addr: exception_o = 1'b1;
        [data_addr:data_end_addr]: begin
          // merge enabled bytes over the debugger copy
          data_valid_o = 1'b1;
          for (int b = 0; b < 4; b++) begin
            if (bus.be[b]) begin
              data_o[data_idx][8*b +: 8] = bus.wdata[8*b +: 8];
            end
          end
        end
        default: ;
      endcase
    end

    // reset harts are neither halted nor resuming
    if (ndmreset_i) begin
      halted_d   = '0;
      resuming_d = '0;
    end
  end

  // ----------------------------------------
  // hart reads
  // ----------------------------------------
  always_comb begin
    rdata_d = rdata_q;
    if (bus.req && !bus.we) begin
      rdata_d = '0;
      unique case (addr) inside
        whereto_addr: begin
          if (resumereq_i[hartsel_i] || cmd_busy_i) begin
            rdata_d = enc_jal(reg_zero, 21'(whereto_tgt - whereto_addr));
          end
        end
        [data_addr:data_end_addr]:             rdata_d = data_i[data_idx];
        [progbuf_base_addr:progbuf_end_addr]:  rdata_d = progbuf_i[pb_idx];
        [abs_cmd_base_addr:abs_cmd_end_addr]:  rdata_d = prog_i[abs_idx];
        [flags_base_addr:flags_end_addr]: begin
          // parked hart polls its own byte
          if (flag_hit) begin
            rdata_d[8*flag_lane +: 8] = {6'b0, resume_i, go_i};
          end
        end
        default: ;
      endcase
    end
  end

  assign bus.rdata  = rdata_q;
  assign halted_o   = halted_q;
  assign resuming_o = resuming_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      halted_q   <= '0;
      resuming_q <= '0;
      rdata_q    <= '0;
    end else begin
      halted_q   <= halted_d;
      resuming_q <= resuming_d;
      rdata_q    <= rdata_d;
    end
  end

endmodule

// ==== hdl/dbg_mem_top.sv ====
// debug memory top level; hart bus and debugger ports, wiring FSM, generator and decoder
`timescale 1ns/1ns
module dbg_mem_top
  import dbg_mem_pkg::*;
(
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          ndmreset_i,
  input  hart_sel_t                     hartsel_i,
  input  logic [nr_harts-1:0]           haltreq_i,
  input  logic [nr_harts-1:0]           resumereq_i,
  input  logic                          clear_resumeack_i,
  output logic [nr_harts-1:0]           debug_req_o,
  output logic [nr_harts-1:0]           halted_o,
  output logic [nr_harts-1:0]           resuming_o,
  input  logic [progbuf_size-1:0][31:0] progbuf_i,
  input  logic [data_count-1:0][31:0]   data_i,
  output logic [data_count-1:0][31:0]   data_o,
  output logic                          data_valid_o,
  input  logic                          cmd_valid_i,
  input  cmd_word_u                     cmd_i,
  output logic                          cmderror_valid_o,
  output cmderr_e                       cmderror_o,
  output logic                          cmdbusy_o,
  input  logic                          req_i,
  input  logic                          we_i,
  input  logic [31:0]                   addr_i,
  input  logic [31:0]                   wdata_i,
  input  logic [3:0]                    be_i,
  output logic [31:0]                   rdata_o
);

  instr_t [abs_cmd_size-1:0] prog;
  logic                      to_progbuf;
  logic                      unsupported;
  logic                      go;
  logic                      resume;
  logic                      going;
  logic [nr_harts-1:0]       halted_w;
  logic                      exception;

  dbg_bus_if i_bus ();

  // hart bus into the interface
  assign i_bus.req   = req_i;
  assign i_bus.we    = we_i;
  assign i_bus.addr  = addr_i;
  assign i_bus.wdata = wdata_i;
  assign i_bus.be    = be_i;
  assign rdata_o     = i_bus.rdata;

  // halt requests go straight to the harts
  assign debug_req_o = haltreq_i;

  hart_ctrl_fsm i_hart_ctrl_fsm (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .ndmreset_i       (ndmreset_i),
    .hartsel_i        (hartsel_i),
    .haltreq_i        (haltreq_i),
    .resumereq_i      (resumereq_i),
    .halted_i         (halted_o),
    .resuming_i       (resuming_o),
    .going_i          (going),
    .halted_w_i       (halted_w),
    .exception_i      (exception),
    .unsupported_i    (unsupported),
    .cmd_valid_i      (cmd_valid_i),
    .go_o             (go),
    .resume_o         (resume),
    .cmd_busy_o       (cmdbusy_o),
    .cmderror_valid_o (cmderror_valid_o),
    .cmderror_o       (cmderror_o)
  );

  abstract_cmd_gen i_abstract_cmd_gen (
    .cmd_i         (cmd_i),
    .prog_o        (prog),
    .to_progbuf_o  (to_progbuf),
    .unsupported_o (unsupported)
  );

  dbg_mem_decoder i_dbg_mem_decoder (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .ndmreset_i        (ndmreset_i),
    .hartsel_i         (hartsel_i),
    .bus               (i_bus),
    .resumereq_i       (resumereq_i),
    .clear_resumeack_i (clear_resumeack_i),
    .go_i              (go),
    .resume_i          (resume),
    .cmd_busy_i        (cmdbusy_o),
    .prog_i            (prog),
    .to_progbuf_i      (to_progbuf),
    .progbuf_i         (progbuf_i),
    .data_i            (data_i),
    .data_o            (data_o),
    .data_valid_o      (data_valid_o),
    .halted_o          (halted_o),
    .resuming_o        (resuming_o),
    .going_o           (going),
    .halted_w_o        (halted_w),
    .exception_o       (exception)
  );

endmodule

// ==== dv/tb_dbg_mem.sv ====
// directed testbench for the debug memory top level; plays hart and debugger, checks responses
`timescale 1ns/1ns
module tb_dbg_mem
  import dbg_mem_pkg::*;
();

  logic                          clk;
  logic                          rst_n;
  logic                          ndmreset;
  hart_sel_t                     hartsel;
  logic [nr_harts-1:0]           haltreq;
  logic [nr_harts-1:0]           resumereq;
  logic                          clear_resumeack;
  logic [nr_harts-1:0]           debug_req;
  logic [nr_harts-1:0]           halted;
  logic [nr_harts-1:0]           resuming;
  logic [progbuf_size-1:0][31:0] progbuf;
  logic [data_count-1:0][31:0]   data_in;
  logic [data_count-1:0][31:0]   data_out;
  logic                          data_valid;
  logic                          cmd_valid;
  cmd_word_u                     cmd;
  logic                          cmderror_valid;
  cmderr_e                       cmderror;
  logic                          cmdbusy;
  logic                          req;
  logic                          we;
  logic [31:0]                   addr;
  logic [31:0]                   wdata;
  logic [3:0]                    be;
  logic [31:0]                   rdata;

  // per-test and overall bookkeeping
  string       test_name;
  int          test_errors;
  int          total_errors;
  int          tests_run;
  int          tests_failed;
  logic [31:0] rnd_state;

  // combinational outputs caught in the middle of a write or command cycle
  logic [data_count-1:0][31:0] seen_data;
  logic                        seen_valid;
  logic                        seen_err_valid;
  logic [2:0]                  seen_err;

  dbg_mem_top i_dbg_mem_top (
    .clk_i             (clk),
    .rst_ni            (rst_n),
    .ndmreset_i        (ndmreset),
    .hartsel_i         (hartsel),
    .haltreq_i         (haltreq),
    .resumereq_i       (resumereq),
    .clear_resumeack_i (clear_resumeack),
    .debug_req_o       (debug_req),
    .halted_o          (halted),
    .resuming_o        (resuming),
    .progbuf_i         (progbuf),
    .data_i            (data_in),
    .data_o            (data_out),
    .data_valid_o      (data_valid),
    .cmd_valid_i       (cmd_valid),
    .cmd_i             (cmd),
    .cmderror_valid_o  (cmderror_valid),
    .cmderror_o        (cmderror),
    .cmdbusy_o         (cmdbusy),
    .req_i             (req),
    .we_i              (we),
    .addr_i            (addr),
    .wdata_i           (wdata),
    .be_i              (be),
    .rdata_o           (rdata)
  );

  // 20 ns period
  always #10 clk = ~clk;

  // ----------------------------------------
  // reference encoders and stimulus helpers
  // ----------------------------------------
  // jal x0 with a byte offset
  function automatic logic [31:0] jal_word(input logic [20:0] off);
    logic [31:0] w;
    w         = 32'h0000_006f;
    w[31]     = off[20];
    w[30:21]  = off[10:1];
    w[20]     = off[11];
    w[19:12]  = off[19:12];
    return w;
  endfunction

  // sw rs2, imm(x0)
  function automatic logic [31:0] store_word(input logic [4:0] rs2, input logic [11:0] imm);
    logic [31:0] w;
    w         = 32'h0000_2023;
    w[24:20]  = rs2;
    w[31:25]  = imm[11:5];
    w[11:7]   = imm[4:0];
    return w;
  endfunction

  // addi x0, x0, 0
  function automatic logic [31:0] nop_word();
    return {12'd0, 5'd0, 3'b000, 5'd0, 7'b0010011};
  endfunction

  function automatic logic [31:0] ebreak_word();
    return {12'd1, 5'd0, 3'b000, 5'd0, 7'b1110011};
  endfunction

  // access register command with postincrement always clear
  function automatic logic [31:0] ar_cmd(
    input logic [2:0]  size,
    input logic        postexec,
    input logic        transfer,
    input logic        write,
    input logic [15:0] regno
  );
    return {8'h00, 1'b0, size, 1'b0, postexec, transfer, write, regno};
  endfunction

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic next_rand(output logic [31:0] v);
    rnd_state = xorshift(rnd_state);
    v = rnd_state;
  endtask

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("error %s: %s expected %08h actual %08h", test_name, what, exp, act);
      test_errors++;
      total_errors++;
    end
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_errors = 0;
  endtask

  task automatic end_test();
    tests_run++;
    if (test_errors == 0) begin
      $display("test %s: ok", test_name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", test_name, test_errors);
    end
  endtask

  // one-cycle hart write that ends at the falling edge after the capture edge
  task automatic hart_write(input logic [31:0] a, input logic [31:0] d, input logic [3:0] b);
    @(posedge clk);
    req   <= 1'b1;
    we    <= 1'b1;
    addr  <= a;
    wdata <= d;
    be    <= b;
    @(negedge clk);
    seen_data      = data_out;
    seen_valid     = data_valid;
    seen_err_valid = cmderror_valid;
    seen_err       = cmderror;
    @(posedge clk);
    req <= 1'b0;
    we  <= 1'b0;
    @(negedge clk);
  endtask

  // read data shows up one cycle after the request
  task automatic hart_read(input logic [31:0] a, output logic [31:0] d);
    @(posedge clk);
    req  <= 1'b1;
    we   <= 1'b0;
    addr <= a;
    @(posedge clk);
    req <= 1'b0;
    @(negedge clk);
    d = rdata;
  endtask

  // command valid pulses for one cycle while the word stays on cmd
  task automatic issue_cmd(input logic [31:0] c);
    @(posedge clk);
    cmd_valid <= 1'b1;
    cmd       <= c;
    @(negedge clk);
    seen_err_valid = cmderror_valid;
    seen_err       = cmderror;
    @(posedge clk);
    cmd_valid <= 1'b0;
    @(negedge clk);
  endtask

  task automatic pulse_ndmreset();
    @(posedge clk);
    ndmreset <= 1'b1;
    @(posedge clk);
    ndmreset <= 1'b0;
    @(negedge clk);
  endtask

  task automatic pulse_clear_resumeack();
    @(posedge clk);
    clear_resumeack <= 1'b1;
    @(posedge clk);
    clear_resumeack <= 1'b0;
    @(negedge clk);
  endtask

  task automatic wait_busy(input logic level);
    int n;
    n = 0;
    while (cmdbusy !== level && n < 20) begin
      @(negedge clk);
      n++;
    end
    assert (cmdbusy === level) else begin
      $display("%s: timed out waiting for cmdbusy_o to become %0d", test_name, level);
      test_errors++;
      total_errors++;
    end
  endtask

  // poll the flag word the way a parked hart does
  task automatic wait_flag(input logic [31:0] exp);
    logic [31:0] got;
    int          n;
    got = '0;
    n   = 0;
    while (got !== exp && n < 20) begin
      hart_read(flags_base_addr, got);
      n++;
    end
    check_value("flag word after polling", exp, got);
  endtask

  // ----------------------------------------
  // directed tests
  // ----------------------------------------
  task automatic halt_and_ndmreset();
    logic [31:0] got;
    start_test("halt_ndmreset");
    // quiet outputs out of reset
    check_value("cmdbusy_o after reset", 32'd0, cmdbusy);
    check_value("cmderror_valid_o after reset", 32'd0, cmderror_valid);
    check_value("data_valid_o after reset", 32'd0, data_valid);
    check_value("halted_o after reset", 32'd0, halted);
    check_value("resuming_o after reset", 32'd0, resuming);
    check_value("rdata_o after reset", 32'd0, rdata);
    @(posedge clk);
    hartsel <= 1'b1;
    haltreq <= 2'b10;
    @(negedge clk);
    // halt request goes straight out to hart 1 only
    check_value("debug_req_o", 32'h2, debug_req);
    hart_write(halted_addr, 32'd1, 4'hf);
    check_value("halted_o", 32'h2, halted);
    @(posedge clk);
    haltreq <= '0;
    // no go or resume pending
    hart_read(flags_base_addr, got);
    check_value("flag word", 32'd0, got);
    check_value("debug_req_o after release", 32'd0, debug_req);
    pulse_ndmreset();
    check_value("halted_o after ndmreset", 32'd0, halted);
    end_test();
  endtask

  task automatic gpr_abstract_read();
    logic [31:0] got;
    logic [31:0] exp;
    start_test("gpr_read");
    @(posedge clk);
    hartsel <= 1'b0;
    hart_write(halted_addr, 32'd0, 4'hf);
    check_value("halted_o", 32'h1, halted);
    // read x5 into data0
    issue_cmd(ar_cmd(3'd2, 1'b0, 1'b1, 1'b0, 16'h1005));
    check_value("cmderror_valid_o", 32'd0, seen_err_valid);
    wait_busy(1'b1);
    hart_read(whereto_addr, got);
    check_value("whereto", jal_word(21'(abs_cmd_base_addr - whereto_addr)), got);
    for (int i = 0; i < abs_cmd_size; i++) begin
      exp = nop_word();
      if (i == 1) begin
        exp = store_word(5'd5, data_addr);
      end
      if (i == abs_cmd_size - 1) begin
        exp = ebreak_word();
      end
      hart_read(abs_cmd_base_addr + 4 * i, got);
      check_value($sformatf("abstract slot %0d", i), exp, got);
    end
    // go bit in lane 0
    hart_read(flags_base_addr, got);
    check_value("flag word", 32'h1, got);
    hart_write(going_addr, 32'd0, 4'hf);
    check_value("cmdbusy_o while executing", 32'd1, cmdbusy);
    hart_write(halted_addr, 32'd0, 4'hf);
    wait_busy(1'b0);
    end_test();
  endtask

  task automatic data_register_access();
    logic [31:0] w;
    logic [31:0] r;
    logic [31:0] d0;
    logic [31:0] d1;
    logic [31:0] exp;
    logic [31:0] got;
    logic [3:0]  b;
    int          idx;
    start_test("data_regs");
    for (int n = 0; n < 8; n++) begin
      next_rand(d0);
      next_rand(d1);
      next_rand(w);
      next_rand(r);
      b   = r[3:0];
      idx = n % data_count;
      @(posedge clk);
      data_in <= {d1, d0};
      hart_write(data_addr + 4 * idx, w, b);
      // enabled bytes come from the hart, the rest from the debugger copy
      exp = (idx == 0) ? d0 : d1;
      for (int k = 0; k < 4; k++) begin
        if (b[k]) begin
          exp[8*k +: 8] = w[8*k +: 8];
        end
      end
      check_value("data_valid_o", 32'd1, seen_valid);
      check_value($sformatf("data_o[%0d]", idx), exp, seen_data[idx]);
      check_value("untouched data_o word", (idx == 0) ? d1 : d0, seen_data[1 - idx]);
      hart_read(data_addr + 4 * idx, got);
      check_value($sformatf("data read %0d", idx), (idx == 0) ? d0 : d1, got);
    end
    end_test();
  endtask

  task automatic command_errors();
    start_test("cmd_errors");
    hart_write(halted_addr, 32'd0, 4'hf);
    // 128-bit access
    issue_cmd(ar_cmd(3'd3, 1'b0, 1'b1, 1'b0, 16'h1005));
    check_value("cmderror_valid_o", 32'd1, seen_err_valid);
    check_value("cmderror_o", cmderr_not_supported, seen_err);
    check_value("cmdbusy_o", 32'd0, cmdbusy);
    // nothing halted any more
    pulse_ndmreset();
    issue_cmd(ar_cmd(3'd2, 1'b0, 1'b1, 1'b0, 16'h1005));
    check_value("cmderror_valid_o", 32'd1, seen_err_valid);
    check_value("cmderror_o", cmderr_halt_resume, seen_err);
    check_value("cmdbusy_o", 32'd0, cmdbusy);
    hart_write(exception_addr, 32'd0, 4'hf);
    check_value("cmderror_valid_o", 32'd1, seen_err_valid);
    check_value("cmderror_o", cmderr_exception, seen_err);
    check_value("cmdbusy_o", 32'd0, cmdbusy);
    end_test();
  endtask

  task automatic hart_resume();
    logic [31:0] got;
    start_test("resume");
    hart_write(halted_addr, 32'd0, 4'hf);
    @(posedge clk);
    resumereq <= 2'b01;
    // resume bit of hart 0
    wait_flag(32'h2);
    hart_write(resuming_addr, 32'd0, 4'hf);
    check_value("resuming_o", 32'h1, resuming);
    check_value("halted_o", 32'h0, halted);
    wait_busy(1'b0);
    hart_read(whereto_addr, got);
    check_value("whereto", jal_word(21'(resume_addr - whereto_addr)), got);
    pulse_clear_resumeack();
    check_value("resuming_o after ack", 32'h0, resuming);
    @(posedge clk);
    resumereq <= 2'b00;
    end_test();
  endtask

  task automatic progbuf_postexec();
    logic [31:0] got;
    start_test("progbuf");
    hart_write(halted_addr, 32'd0, 4'hf);
    // no transfer, straight into the program buffer
    issue_cmd(ar_cmd(3'd2, 1'b1, 1'b0, 1'b0, 16'h1005));
    check_value("cmderror_valid_o", 32'd0, seen_err_valid);
    wait_busy(1'b1);
    hart_read(whereto_addr, got);
    check_value("whereto", jal_word(21'(progbuf_base_addr - whereto_addr)), got);
    for (int i = 0; i < progbuf_size; i++) begin
      hart_read(progbuf_base_addr + 4 * i, got);
      check_value($sformatf("progbuf %0d", i), progbuf[i], got);
    end
    hart_read(abs_cmd_base_addr, got);
    check_value("abstract slot 0", nop_word(), got);
    hart_read(abs_cmd_base_addr + 4 * (abs_cmd_size - 1), got);
    check_value("abstract slot 9", nop_word(), got);
    hart_write(going_addr, 32'd0, 4'hf);
    hart_write(halted_addr, 32'd0, 4'hf);
    wait_busy(1'b0);
    end_test();
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------
  initial begin
    logic [31:0] v;
    clk             = 1'b0;
    rst_n           = 1'b0;
    ndmreset        = 1'b0;
    hartsel         = 1'b0;
    haltreq         = '0;
    resumereq       = '0;
    clear_resumeack = 1'b0;
    cmd_valid       = 1'b0;
    cmd             = '0;
    req             = 1'b0;
    we              = 1'b0;
    addr            = '0;
    wdata           = '0;
    be              = '0;
    data_in         = '0;
    rnd_state       = 32'h2d285910;
    total_errors    = 0;
    tests_run       = 0;
    tests_failed    = 0;
    for (int i = 0; i < progbuf_size; i++) begin
      next_rand(v);
      progbuf[i] = v;
    end
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);

    halt_and_ndmreset();
    gpr_abstract_read();
    data_register_access();
    command_errors();
    hart_resume();
    progbuf_postexec();

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
             total_errors);
    if (total_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== all.f ====
hdl/dbg_mem_pkg.sv
hdl/dbg_bus_if.sv
hdl/hart_ctrl_fsm.sv
hdl/abstract_cmd_gen.sv
hdl/dbg_mem_decoder.sv
hdl/dbg_mem_top.sv
dv/tb_dbg_mem.sv
